// File: rtl/ex_cfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// execute lanes, one per thread context
// any power of two from 2 to 8
`define EX_LANES 4

// bits needed to number a lane
`define EX_LANE_ID_W $clog2(`EX_LANES)

// operand and result width
`define EX_WORD_W 32

// signed ALU immediate
`define EX_IMM_W 17

// sprite number, 8 attribute bytes per sprite
`define EX_SPRITE_W 8

// byte address into sprite attribute memory (2048 bytes)
`define EX_SPRITE_MEM_AW 11

// immediate field of a sprite op, only the low byte is stored
`define EX_SPRITE_IMM_W 14

`endif

// File: rtl/ex_pkg.sv
package ex_pkg;

	`include "ex_cfg.svh"

	typedef logic [`EX_WORD_W-1:0] word_t;
	typedef logic signed [`EX_IMM_W-1:0] imm_t;
	typedef logic [2:0] alu_op_t;
	typedef logic [`EX_SPRITE_W-1:0] sprite_id_t;
	typedef logic [3:0] sprite_act_t;
	typedef logic [7:0] sprite_byte_t;
	typedef logic [`EX_SPRITE_MEM_AW-1:0] sprite_maddr_t;
	typedef logic [`EX_LANE_ID_W-1:0] lane_id_t;
	// byte offset inside one sprite's 8-byte record
	typedef logic [2:0] sprite_off_t;

	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR  = 3'd3;
	localparam alu_op_t ALU_NOR = 3'd4;
	localparam alu_op_t ALU_SLL = 3'd5;
	localparam alu_op_t ALU_SRL = 3'd6;
	localparam alu_op_t ALU_SRA = 3'd7;

	// action codes that select a non-data attribute byte
	localparam sprite_act_t SPR_ACT_BYTE1 = 4'd8;
	localparam sprite_act_t SPR_ACT_BYTE2 = 4'd9;
	localparam sprite_act_t SPR_ACT_BYTE4 = 4'd3;
	localparam sprite_act_t SPR_ACT_BYTE5 = 4'd7;
	localparam sprite_act_t SPR_ACT_BYTE6 = 4'd0;
	localparam sprite_act_t SPR_ACT_BYTE7 = 4'd2;

	// every other action lands on the data byte
	localparam sprite_off_t SPR_OFF_DATA  = 3'd0;
	localparam sprite_off_t SPR_OFF_BYTE1 = 3'd1;
	localparam sprite_off_t SPR_OFF_BYTE2 = 3'd2;
	localparam sprite_off_t SPR_OFF_BYTE4 = 3'd4;
	localparam sprite_off_t SPR_OFF_BYTE5 = 3'd5;
	localparam sprite_off_t SPR_OFF_BYTE6 = 3'd6;
	localparam sprite_off_t SPR_OFF_BYTE7 = 3'd7;

endpackage

// File: rtl/ex_dispatch.sv
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_dispatch (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        op_valid,
	input  ex_pkg::lane_id_t            op_lane,
	input  ex_pkg::alu_op_t             alu_opcode,
	input  ex_pkg::word_t               s_data,
	input  ex_pkg::word_t               t_data,
	input  ex_pkg::imm_t                imm,
	input  logic                        use_imm,
	input  logic                        upd_ov,
	input  logic                        upd_neg,
	input  logic                        upd_zero,
	input  logic                        sprite_re,
	input  logic                        sprite_we,
	input  ex_pkg::sprite_act_t         sprite_action,
	input  ex_pkg::sprite_id_t          sprite_addr,
	input  logic [`EX_SPRITE_IMM_W-1:0] sprite_imm,
	input  logic                        sprite_use_imm,
	output logic [`EX_LANES-1:0]        issue,
	output ex_pkg::alu_op_t             d_alu_opcode,
	output ex_pkg::word_t               d_s_data,
	output ex_pkg::word_t               d_t_data,
	output ex_pkg::imm_t                d_imm,
	output logic                        d_use_imm,
	output logic                        d_upd_ov,
	output logic                        d_upd_neg,
	output logic                        d_upd_zero,
	output logic                        d_sprite_re,
	output logic                        d_sprite_we,
	output ex_pkg::sprite_act_t         d_sprite_action,
	output ex_pkg::sprite_id_t          d_sprite_addr,
	output logic [`EX_SPRITE_IMM_W-1:0] d_sprite_imm,
	output logic                        d_sprite_use_imm
);

	logic [`EX_LANES-1:0] issue_next;

	// one-hot lane select, empty on idle cycles
	always_comb begin
		issue_next = '0;
		if (op_valid) begin
			issue_next[op_lane] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issue <= '0;
		end else begin
			issue <= issue_next;
		end
	end

	// op fields hold their value between ops so the lanes stay quiet
	always_ff @(posedge clk) begin
		if (op_valid) begin
			d_alu_opcode     <= alu_opcode;
			d_s_data         <= s_data;
			d_t_data         <= t_data;
			d_imm            <= imm;
			d_use_imm        <= use_imm;
			d_upd_ov         <= upd_ov;
			d_upd_neg        <= upd_neg;
			d_upd_zero       <= upd_zero;
			d_sprite_re      <= sprite_re;
			d_sprite_we      <= sprite_we;
			d_sprite_action  <= sprite_action;
			d_sprite_addr    <= sprite_addr;
			d_sprite_imm     <= sprite_imm;
			d_sprite_use_imm <= sprite_use_imm;
		end
	end

endmodule

// File: rtl/ex_lane.sv
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_lane (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        issue,
	input  ex_pkg::alu_op_t             d_alu_opcode,
	input  ex_pkg::word_t               d_s_data,
	input  ex_pkg::word_t               d_t_data,
	input  ex_pkg::imm_t                d_imm,
	input  logic                        d_use_imm,
	input  logic                        d_upd_ov,
	input  logic                        d_upd_neg,
	input  logic                        d_upd_zero,
	input  logic                        d_sprite_re,
	input  logic                        d_sprite_we,
	input  ex_pkg::sprite_act_t         d_sprite_action,
	input  ex_pkg::sprite_id_t          d_sprite_addr,
	input  logic [`EX_SPRITE_IMM_W-1:0] d_sprite_imm,
	input  logic                        d_sprite_use_imm,
	output logic                        lane_valid,
	output ex_pkg::word_t               lane_result,
	output logic                        lane_sprite_re,
	output logic                        lane_sprite_we,
	output ex_pkg::sprite_maddr_t       lane_sprite_maddr,
	output ex_pkg::sprite_byte_t        lane_sprite_wdata,
	output logic                        flag_ov,
	output logic                        flag_neg,
	output logic                        flag_zero
);

	localparam int MSB = `EX_WORD_W - 1;

	ex_pkg::word_t        opa;
	ex_pkg::word_t        opb;
	ex_pkg::word_t        opb_add;
	ex_pkg::word_t        sum;
	ex_pkg::word_t        alu_result;
	logic                 is_sub;
	logic [4:0]           shamt;
	logic                 ov;
	logic                 neg;
	logic                 zero;
	ex_pkg::sprite_off_t  spr_off;
	ex_pkg::sprite_maddr_t spr_maddr;
	ex_pkg::sprite_byte_t spr_wdata;

	assign opa = d_s_data;
	assign opb = d_use_imm ? {{(`EX_WORD_W - `EX_IMM_W){d_imm[`EX_IMM_W-1]}}, d_imm} : d_t_data;

	// single adder, sub is a + ~b + 1
	assign is_sub  = (d_alu_opcode == ex_pkg::ALU_SUB);
	assign opb_add = is_sub ? ~opb : opb;
	assign sum     = opa + opb_add + ex_pkg::word_t'(is_sub);

	// shift amount comes from the selected second operand, immediate included
	assign shamt = opb[4:0];

	always_comb begin
		case (d_alu_opcode)
			ex_pkg::ALU_ADD: alu_result = sum;
			ex_pkg::ALU_SUB: alu_result = sum;
			ex_pkg::ALU_AND: alu_result = opa & opb;
			ex_pkg::ALU_OR:  alu_result = opa | opb;
			ex_pkg::ALU_NOR: alu_result = ~(opa | opb);
			ex_pkg::ALU_SLL: alu_result = opa << shamt;
			ex_pkg::ALU_SRL: alu_result = opa >> shamt;
			default:         alu_result = ex_pkg::word_t'($signed(opa) >>> shamt);
		endcase
	end

	// ov and neg always come from the adder, whatever the opcode
	// for sub opb_add holds ~b, so one compare covers both cases
	assign ov   = (opa[MSB] == opb_add[MSB]) && (sum[MSB] != opa[MSB]);
	assign neg  = sum[MSB] ^ ov;
	assign zero = (alu_result == '0);

	// attribute byte inside the sprite's 8-byte record
	always_comb begin
		case (d_sprite_action)
			ex_pkg::SPR_ACT_BYTE1: spr_off = ex_pkg::SPR_OFF_BYTE1;
			ex_pkg::SPR_ACT_BYTE2: spr_off = ex_pkg::SPR_OFF_BYTE2;
			ex_pkg::SPR_ACT_BYTE4: spr_off = ex_pkg::SPR_OFF_BYTE4;
			ex_pkg::SPR_ACT_BYTE5: spr_off = ex_pkg::SPR_OFF_BYTE5;
			ex_pkg::SPR_ACT_BYTE6: spr_off = ex_pkg::SPR_OFF_BYTE6;
			ex_pkg::SPR_ACT_BYTE7: spr_off = ex_pkg::SPR_OFF_BYTE7;
			default:               spr_off = ex_pkg::SPR_OFF_DATA;
		endcase
	end

	assign spr_maddr = {d_sprite_addr, 3'b000} + ex_pkg::sprite_maddr_t'(spr_off);
	assign spr_wdata = d_sprite_use_imm ? d_sprite_imm[7:0] : opa[7:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lane_valid     <= 1'b0;
			lane_sprite_re <= 1'b0;
			lane_sprite_we <= 1'b0;
		end else begin
			lane_valid     <= issue;
			lane_sprite_re <= issue & d_sprite_re;
			lane_sprite_we <= issue & d_sprite_we;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			lane_result       <= alu_result;
			lane_sprite_maddr <= spr_maddr;
			lane_sprite_wdata <= spr_wdata;
		end
	end

	// sticky flags, each one moves only with its own strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flag_ov   <= 1'b0;
			flag_neg  <= 1'b0;
			flag_zero <= 1'b0;
		end else if (issue) begin
			if (d_upd_ov) begin
				flag_ov <= ov;
			end
			if (d_upd_neg) begin
				flag_neg <= neg;
			end
			if (d_upd_zero) begin
				flag_zero <= zero;
			end
		end
	end

endmodule

// File: rtl/sprite_writeback.sv
`timescale 1ns/100ps

`include "ex_cfg.svh"

module sprite_writeback (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic [`EX_LANES-1:0]                      lane_valid,
	input  logic [`EX_LANES*`EX_WORD_W-1:0]           lane_result,
	input  logic [`EX_LANES-1:0]                      lane_sprite_re,
	input  logic [`EX_LANES-1:0]                      lane_sprite_we,
	input  logic [`EX_LANES*`EX_SPRITE_MEM_AW-1:0]    lane_sprite_maddr,
	input  logic [`EX_LANES*8-1:0]                    lane_sprite_wdata,
	output logic                                      result_valid,
	output ex_pkg::word_t                             result,
	output ex_pkg::lane_id_t                          result_lane,
	output logic                                      sprite_rd_valid,
	output ex_pkg::sprite_byte_t                      sprite_rd_data
);

	localparam int WW    = `EX_WORD_W;
	localparam int AW    = `EX_SPRITE_MEM_AW;
	localparam int LW    = `EX_LANE_ID_W;
	localparam int DEPTH = 1 << `EX_SPRITE_MEM_AW;

	logic                  any_valid;
	ex_pkg::word_t         sel_result;
	ex_pkg::lane_id_t      sel_lane;
	logic                  sel_re;
	logic                  sel_we;
	ex_pkg::sprite_maddr_t sel_maddr;
	ex_pkg::sprite_byte_t  sel_wdata;

	// attribute bytes, 8 per sprite
	ex_pkg::sprite_byte_t  sprite_mem [0:DEPTH-1];

	assign any_valid = |lane_valid;

	// at most one lane is valid per cycle, so a masked OR is the mux
	always_comb begin
		sel_result = '0;
		sel_lane   = '0;
		sel_re     = 1'b0;
		sel_we     = 1'b0;
		sel_maddr  = '0;
		sel_wdata  = '0;
		for (int i = 0; i < `EX_LANES; i++) begin
			sel_result = sel_result | (lane_result[i*WW +: WW] & {WW{lane_valid[i]}});
			sel_lane   = sel_lane | (ex_pkg::lane_id_t'(i) & {LW{lane_valid[i]}});
			sel_re     = sel_re | (lane_sprite_re[i] & lane_valid[i]);
			sel_we     = sel_we | (lane_sprite_we[i] & lane_valid[i]);
			sel_maddr  = sel_maddr | (lane_sprite_maddr[i*AW +: AW] & {AW{lane_valid[i]}});
			sel_wdata  = sel_wdata | (lane_sprite_wdata[i*8 +: 8] & {8{lane_valid[i]}});
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result_valid    <= 1'b0;
			sprite_rd_valid <= 1'b0;
		end else begin
			result_valid    <= any_valid;
			sprite_rd_valid <= sel_re;
		end
	end

	always_ff @(posedge clk) begin
		if (any_valid) begin
			result      <= sel_result;
			result_lane <= sel_lane;
		end
	end

	// read and write share the edge, so a read sees the byte before the write
	always_ff @(posedge clk) begin
		if (sel_we) begin
			sprite_mem[sel_maddr] <= sel_wdata;
		end
		if (sel_re) begin
			sprite_rd_data <= sprite_mem[sel_maddr];
		end
	end

endmodule

// File: rtl/ex_cluster_top.sv
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_cluster_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        op_valid,
	input  ex_pkg::lane_id_t            op_lane,
	input  ex_pkg::alu_op_t             alu_opcode,
	input  ex_pkg::word_t               s_data,
	input  ex_pkg::word_t               t_data,
	input  ex_pkg::imm_t                imm,
	input  logic                        use_imm,
	input  logic                        upd_ov,
	input  logic                        upd_neg,
	input  logic                        upd_zero,
	input  logic                        sprite_re,
	input  logic                        sprite_we,
	input  ex_pkg::sprite_act_t         sprite_action,
	input  ex_pkg::sprite_id_t          sprite_addr,
	input  logic [`EX_SPRITE_IMM_W-1:0] sprite_imm,
	input  logic                        sprite_use_imm,
	output logic                        result_valid,
	output ex_pkg::word_t               result,
	output ex_pkg::lane_id_t            result_lane,
	output logic                        sprite_rd_valid,
	output ex_pkg::sprite_byte_t        sprite_rd_data,
	output logic [`EX_LANES-1:0]        flag_ov,
	output logic [`EX_LANES-1:0]        flag_neg,
	output logic [`EX_LANES-1:0]        flag_zero
);

	localparam int WW = `EX_WORD_W;
	localparam int AW = `EX_SPRITE_MEM_AW;

	logic [`EX_LANES-1:0]              issue;
	ex_pkg::alu_op_t                   d_alu_opcode;
	ex_pkg::word_t                     d_s_data;
	ex_pkg::word_t                     d_t_data;
	ex_pkg::imm_t                      d_imm;
	logic                              d_use_imm;
	logic                              d_upd_ov;
	logic                              d_upd_neg;
	logic                              d_upd_zero;
	logic                              d_sprite_re;
	logic                              d_sprite_we;
	ex_pkg::sprite_act_t               d_sprite_action;
	ex_pkg::sprite_id_t                d_sprite_addr;
	logic [`EX_SPRITE_IMM_W-1:0]       d_sprite_imm;
	logic                              d_sprite_use_imm;

	// lane outputs, flattened by lane index
	logic [`EX_LANES-1:0]              lane_valid;
	logic [`EX_LANES*WW-1:0]           lane_result;
	logic [`EX_LANES-1:0]              lane_sprite_re;
	logic [`EX_LANES-1:0]              lane_sprite_we;
	logic [`EX_LANES*AW-1:0]           lane_sprite_maddr;
	logic [`EX_LANES*8-1:0]            lane_sprite_wdata;

	ex_dispatch ex_dispatch_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.op_valid         (op_valid),
		.op_lane          (op_lane),
		.alu_opcode       (alu_opcode),
		.s_data           (s_data),
		.t_data           (t_data),
		.imm              (imm),
		.use_imm          (use_imm),
		.upd_ov           (upd_ov),
		.upd_neg          (upd_neg),
		.upd_zero         (upd_zero),
		.sprite_re        (sprite_re),
		.sprite_we        (sprite_we),
		.sprite_action    (sprite_action),
		.sprite_addr      (sprite_addr),
		.sprite_imm       (sprite_imm),
		.sprite_use_imm   (sprite_use_imm),
		.issue            (issue),
		.d_alu_opcode     (d_alu_opcode),
		.d_s_data         (d_s_data),
		.d_t_data         (d_t_data),
		.d_imm            (d_imm),
		.d_use_imm        (d_use_imm),
		.d_upd_ov         (d_upd_ov),
		.d_upd_neg        (d_upd_neg),
		.d_upd_zero       (d_upd_zero),
		.d_sprite_re      (d_sprite_re),
		.d_sprite_we      (d_sprite_we),
		.d_sprite_action  (d_sprite_action),
		.d_sprite_addr    (d_sprite_addr),
		.d_sprite_imm     (d_sprite_imm),
		.d_sprite_use_imm (d_sprite_use_imm)
	);

	// one lane per thread context, all fed the same broadcast op
	for (genvar i = 0; i < `EX_LANES; i++) begin : g_lane
		ex_lane ex_lane_inst (
			.clk               (clk),
			.rst_n             (rst_n),
			.issue             (issue[i]),
			.d_alu_opcode      (d_alu_opcode),
			.d_s_data          (d_s_data),
			.d_t_data          (d_t_data),
			.d_imm             (d_imm),
			.d_use_imm         (d_use_imm),
			.d_upd_ov          (d_upd_ov),
			.d_upd_neg         (d_upd_neg),
			.d_upd_zero        (d_upd_zero),
			.d_sprite_re       (d_sprite_re),
			.d_sprite_we       (d_sprite_we),
			.d_sprite_action   (d_sprite_action),
			.d_sprite_addr     (d_sprite_addr),
			.d_sprite_imm      (d_sprite_imm),
			.d_sprite_use_imm  (d_sprite_use_imm),
			.lane_valid        (lane_valid[i]),
			.lane_result       (lane_result[i*WW +: WW]),
			.lane_sprite_re    (lane_sprite_re[i]),
			.lane_sprite_we    (lane_sprite_we[i]),
			.lane_sprite_maddr (lane_sprite_maddr[i*AW +: AW]),
			.lane_sprite_wdata (lane_sprite_wdata[i*8 +: 8]),
			.flag_ov           (flag_ov[i]),
			.flag_neg          (flag_neg[i]),
			.flag_zero         (flag_zero[i])
		);
	end

	sprite_writeback sprite_writeback_inst (
		.clk               (clk),
		.rst_n             (rst_n),
		.lane_valid        (lane_valid),
		.lane_result       (lane_result),
		.lane_sprite_re    (lane_sprite_re),
		.lane_sprite_we    (lane_sprite_we),
		.lane_sprite_maddr (lane_sprite_maddr),
		.lane_sprite_wdata (lane_sprite_wdata),
		.result_valid      (result_valid),
		.result            (result),
		.result_lane       (result_lane),
		.sprite_rd_valid   (sprite_rd_valid),
		.sprite_rd_data    (sprite_rd_data)
	);

endmodule

// File: verification/tb_ex_cluster.sv
`timescale 1ns/100ps

`include "ex_cfg.svh"

module tb_ex_cluster;

	localparam int MSB        = `EX_WORD_W - 1;
	localparam int ALU_OPS    = 400;
	localparam int FLAG_RAND  = 100;
	localparam int FLAG_OPS   = 6 * `EX_LANES + FLAG_RAND;
	// each op may be followed by an idle cycle plus drain time per test
	localparam int RESET_LEN  = 10;
	localparam int ALU_LEN    = 2 * ALU_OPS + 20;
	localparam int FLAG_LEN   = 2 * FLAG_OPS + 20;
	localparam int SPRITE_LEN = 2 * 32 + 20;
	localparam int RBW_LEN    = 20;
	localparam int TIMEOUT_CYCLES = RESET_LEN + ALU_LEN + FLAG_LEN + SPRITE_LEN + RBW_LEN + 100;

	logic                        clk;
	logic                        rst_n;
	logic                        op_valid;
	ex_pkg::lane_id_t            op_lane;
	ex_pkg::alu_op_t             alu_opcode;
	ex_pkg::word_t               s_data;
	ex_pkg::word_t               t_data;
	ex_pkg::imm_t                imm;
	logic                        use_imm;
	logic                        upd_ov;
	logic                        upd_neg;
	logic                        upd_zero;
	logic                        sprite_re;
	logic                        sprite_we;
	ex_pkg::sprite_act_t         sprite_action;
	ex_pkg::sprite_id_t          sprite_addr;
	logic [`EX_SPRITE_IMM_W-1:0] sprite_imm;
	logic                        sprite_use_imm;
	logic                        result_valid;
	ex_pkg::word_t               result;
	ex_pkg::lane_id_t            result_lane;
	logic                        sprite_rd_valid;
	ex_pkg::sprite_byte_t        sprite_rd_data;
	logic [`EX_LANES-1:0]        flag_ov;
	logic [`EX_LANES-1:0]        flag_neg;
	logic [`EX_LANES-1:0]        flag_zero;

	int          cycle = 0;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	logic [31:0] rand_state = 32'd65372;

	// expected writeback per op in issue order
	int                   exp_due[$];
	ex_pkg::word_t        exp_result[$];
	ex_pkg::lane_id_t     exp_lane[$];
	logic                 exp_rd[$];
	logic                 exp_rd_known[$];
	ex_pkg::sprite_byte_t exp_rd_data[$];

	// pending flag updates applied to the model on their due cycle
	int                   fl_due[$];
	ex_pkg::lane_id_t     fl_lane[$];
	logic [2:0]           fl_upd[$];
	logic [2:0]           fl_val[$];

	logic [`EX_LANES-1:0] model_ov;
	logic [`EX_LANES-1:0] model_neg;
	logic [`EX_LANES-1:0] model_zero;
	ex_pkg::sprite_byte_t model_mem [0:2047];
	bit                   mem_known [0:2047];

	ex_cluster_top ex_cluster_top_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.op_valid        (op_valid),
		.op_lane         (op_lane),
		.alu_opcode      (alu_opcode),
		.s_data          (s_data),
		.t_data          (t_data),
		.imm             (imm),
		.use_imm         (use_imm),
		.upd_ov          (upd_ov),
		.upd_neg         (upd_neg),
		.upd_zero        (upd_zero),
		.sprite_re       (sprite_re),
		.sprite_we       (sprite_we),
		.sprite_action   (sprite_action),
		.sprite_addr     (sprite_addr),
		.sprite_imm      (sprite_imm),
		.sprite_use_imm  (sprite_use_imm),
		.result_valid    (result_valid),
		.result          (result),
		.result_lane     (result_lane),
		.sprite_rd_valid (sprite_rd_valid),
		.sprite_rd_data  (sprite_rd_data),
		.flag_ov         (flag_ov),
		.flag_neg        (flag_neg),
		.flag_zero       (flag_zero)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state ^ (rand_state >> 16);
	endfunction

	function automatic ex_pkg::word_t alu_model(input ex_pkg::alu_op_t opc,
			input ex_pkg::word_t a, input ex_pkg::word_t b);
		logic [4:0] sh;
		sh = b[4:0];
		case (opc)
			ex_pkg::ALU_ADD: return a + b;
			ex_pkg::ALU_SUB: return a - b;
			ex_pkg::ALU_AND: return a & b;
			ex_pkg::ALU_OR:  return a | b;
			ex_pkg::ALU_NOR: return ~(a | b);
			ex_pkg::ALU_SLL: return a << sh;
			ex_pkg::ALU_SRL: return a >> sh;
			default:         return (a >> sh) | (a[MSB] ? ~(32'hffffffff >> sh) : 32'h0);
		endcase
	endfunction

	// returns {ov, neg, zero} where ov and neg follow add unless the op is sub
	function automatic logic [2:0] flag_model(input ex_pkg::alu_op_t opc,
			input ex_pkg::word_t a, input ex_pkg::word_t b);
		ex_pkg::word_t sum;
		logic          ov;
		if (opc == ex_pkg::ALU_SUB) begin
			sum = a - b;
			ov  = (a[MSB] != b[MSB]) && (sum[MSB] != a[MSB]);
		end else begin
			sum = a + b;
			ov  = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
		end
		return {ov, sum[MSB] ^ ov, alu_model(opc, a, b) == 32'h0};
	endfunction

	function automatic logic [2:0] action_offset(input ex_pkg::sprite_act_t act);
		case (act)
			4'd8:    return 3'd1;
			4'd9:    return 3'd2;
			4'd3:    return 3'd4;
			4'd7:    return 3'd5;
			4'd0:    return 3'd6;
			4'd2:    return 3'd7;
			default: return 3'd0;
		endcase
	endfunction

	task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
		$display("[ERROR] %s: expected %h, got %h (cycle %0d)", name, exp, got, cycle);
		errors++;
	endtask

	task automatic send_op(input ex_pkg::lane_id_t lane, input ex_pkg::alu_op_t opc,
			input ex_pkg::word_t s, input ex_pkg::word_t t, input ex_pkg::imm_t im,
			input logic ui, input logic [2:0] upd, input logic re, input logic we,
			input ex_pkg::sprite_act_t act, input ex_pkg::sprite_id_t spr,
			input logic [13:0] simm, input logic suse);
		ex_pkg::word_t  b;
		logic [10:0]    addr;
		int             base;
		@(posedge clk);
		op_valid       <= 1'b1;
		op_lane        <= lane;
		alu_opcode     <= opc;
		s_data         <= s;
		t_data         <= t;
		imm            <= im;
		use_imm        <= ui;
		upd_ov         <= upd[2];
		upd_neg        <= upd[1];
		upd_zero       <= upd[0];
		sprite_re      <= re;
		sprite_we      <= we;
		sprite_action  <= act;
		sprite_addr    <= spr;
		sprite_imm     <= simm;
		sprite_use_imm <= suse;
		// edge that follows this drive samples the op
		base = cycle + 1;
		b    = ui ? {{15{im[16]}}, im} : t;
		addr = {spr, 3'b000} + {8'h00, action_offset(act)};
		exp_due.push_back(base + 3);
		exp_result.push_back(alu_model(opc, s, b));
		exp_lane.push_back(lane);
		exp_rd.push_back(re);
		exp_rd_known.push_back(re && mem_known[addr]);
		exp_rd_data.push_back(model_mem[addr]);
		fl_due.push_back(base + 2);
		fl_lane.push_back(lane);
		fl_upd.push_back(upd);
		fl_val.push_back(flag_model(opc, s, b));
		if (we) begin
			model_mem[addr] = suse ? simm[7:0] : s[7:0];
			mem_known[addr] = 1'b1;
		end
	endtask

	task automatic send_idle();
		@(posedge clk);
		op_valid <= 1'b0;
	endtask

	task automatic drain_pipeline();
		send_idle();
		while (exp_due.size() != 0 || fl_due.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (errors != start_errors) begin
			tests_failed++;
		end
		$display("test %s %s, %0d errors", name,
			(errors != start_errors) ? "failed" : "passed", errors - start_errors);
	endtask

	// writeback and flag monitor sampled on the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			while (fl_due.size() != 0 && fl_due[0] == cycle) begin
				if (fl_upd[0][2]) model_ov[fl_lane[0]] = fl_val[0][2];
				if (fl_upd[0][1]) model_neg[fl_lane[0]] = fl_val[0][1];
				if (fl_upd[0][0]) model_zero[fl_lane[0]] = fl_val[0][0];
				void'(fl_due.pop_front());
				void'(fl_lane.pop_front());
				void'(fl_upd.pop_front());
				void'(fl_val.pop_front());
			end
			if (flag_ov !== model_ov) value_error("flag_ov", 32'(model_ov), 32'(flag_ov));
			if (flag_neg !== model_neg) value_error("flag_neg", 32'(model_neg), 32'(flag_neg));
			if (flag_zero !== model_zero) value_error("flag_zero", 32'(model_zero), 32'(flag_zero));
			if (exp_due.size() != 0 && exp_due[0] == cycle) begin
				if (result_valid !== 1'b1) value_error("result_valid", 32'h1, 32'(result_valid));
				if (result !== exp_result[0]) value_error("result", exp_result[0], result);
				if (result_lane !== exp_lane[0]) begin
					value_error("result_lane", 32'(exp_lane[0]), 32'(result_lane));
				end
				if (sprite_rd_valid !== exp_rd[0]) begin
					value_error("sprite_rd_valid", 32'(exp_rd[0]), 32'(sprite_rd_valid));
				end
				if (exp_rd_known[0] && sprite_rd_data !== exp_rd_data[0]) begin
					value_error("sprite_rd_data", 32'(exp_rd_data[0]), 32'(sprite_rd_data));
				end
				void'(exp_due.pop_front());
				void'(exp_result.pop_front());
				void'(exp_lane.pop_front());
				void'(exp_rd.pop_front());
				void'(exp_rd_known.pop_front());
				void'(exp_rd_data.pop_front());
			end else begin
				if (result_valid !== 1'b0) value_error("result_valid", 32'h0, 32'(result_valid));
				if (sprite_rd_valid !== 1'b0) begin
					value_error("sprite_rd_valid", 32'h0, 32'(sprite_rd_valid));
				end
			end
		end
	end

	task automatic check_reset_state();
		int start;
		start = errors;
		if (result_valid !== 1'b0) value_error("result_valid", 32'h0, 32'(result_valid));
		if (sprite_rd_valid !== 1'b0) value_error("sprite_rd_valid", 32'h0, 32'(sprite_rd_valid));
		if (flag_ov !== '0) value_error("flag_ov", 32'h0, 32'(flag_ov));
		if (flag_neg !== '0) value_error("flag_neg", 32'h0, 32'(flag_neg));
		if (flag_zero !== '0) value_error("flag_zero", 32'h0, 32'(flag_zero));
		report_test("reset", start);
	endtask

	task automatic alu_random_ops();
		int          start;
		logic [31:0] ra;
		logic [31:0] rb;
		logic [31:0] rc;
		start = errors;
		for (int n = 0; n < ALU_OPS; n++) begin
			ra = next_rand();
			rb = next_rand();
			rc = next_rand();
			send_op(ex_pkg::lane_id_t'(rc >> 8), rc[2:0], ra, rb, ex_pkg::imm_t'(rc >> 12),
				rc[3], rc[6:4], 1'b0, 1'b0, 4'd0, 8'd0, 14'd0, 1'b0);
			// ops run back to back apart from an occasional gap
			if (rc[31:29] == 3'b000) begin
				send_idle();
			end
		end
		drain_pipeline();
		report_test("alu", start);
	endtask

	task automatic flag_directed_ops();
		int             start;
		logic [31:0]    rc;
		ex_pkg::word_t  pa [0:5];
		ex_pkg::word_t  pb [0:5];
		start = errors;
		// overflow and zero cases with adds first and subs after
		pa[0] = 32'h7fffffff;
		pb[0] = 32'h00000001;
		pa[1] = 32'h80000000;
		pb[1] = 32'h80000000;
		pa[2] = 32'hffffffff;
		pb[2] = 32'h00000001;
		pa[3] = 32'h80000000;
		pb[3] = 32'h00000001;
		pa[4] = 32'h7fffffff;
		pb[4] = 32'hffffffff;
		pa[5] = 32'h12345678;
		pb[5] = 32'h12345678;
		for (int p = 0; p < 6; p++) begin
			for (int l = 0; l < `EX_LANES; l++) begin
				send_op(ex_pkg::lane_id_t'(l), (p < 3) ? ex_pkg::ALU_ADD : ex_pkg::ALU_SUB,
					pa[p], pb[p], '0, 1'b0, 3'b111, 1'b0, 1'b0, 4'd0, 8'd0, 14'd0, 1'b0);
			end
		end
		for (int n = 0; n < FLAG_RAND; n++) begin
			rc = next_rand();
			send_op(ex_pkg::lane_id_t'(rc >> 8), rc[0] ? ex_pkg::ALU_SUB : ex_pkg::ALU_ADD,
				pa[rc[14:12] % 6], pb[rc[18:16] % 6], '0, 1'b0, rc[6:4],
				1'b0, 1'b0, 4'd0, 8'd0, 14'd0, 1'b0);
		end
		drain_pipeline();
		report_test("flags", start);
	endtask

	task automatic sprite_address_sweep();
		int                 start;
		logic [31:0]        ra;
		logic [31:0]        rc;
		ex_pkg::sprite_id_t spr [0:15];
		start = errors;
		for (int a = 0; a < 16; a++) begin
			ra = next_rand();
			rc = next_rand();
			spr[a] = rc[23:16];
			send_op(ex_pkg::lane_id_t'(rc >> 8), rc[2:0], ra, 32'h0, '0, 1'b0, 3'b000,
				1'b0, 1'b1, 4'(a), spr[a], rc[13:0], a[0]);
		end
		for (int a = 0; a < 16; a++) begin
			rc = next_rand();
			send_op(ex_pkg::lane_id_t'(rc >> 8), ex_pkg::ALU_ADD, 32'h0, 32'h0, '0, 1'b0, 3'b000,
				1'b1, 1'b0, 4'(a), spr[a], 14'd0, 1'b0);
		end
		drain_pipeline();
		report_test("sprite", start);
	endtask

	task automatic read_before_write();
		int start;
		start = errors;
		send_op(ex_pkg::lane_id_t'(1), ex_pkg::ALU_OR, 32'h0, 32'h0, '0, 1'b0, 3'b000,
			1'b0, 1'b1, 4'd8, 8'h5a, 14'h003c, 1'b1);
		// read and write of the same byte returns the old byte
		send_op(ex_pkg::lane_id_t'(2), ex_pkg::ALU_OR, 32'h000000c3, 32'h0, '0, 1'b0, 3'b000,
			1'b1, 1'b1, 4'd8, 8'h5a, 14'h0000, 1'b0);
		send_op(ex_pkg::lane_id_t'(3), ex_pkg::ALU_OR, 32'h0, 32'h0, '0, 1'b0, 3'b000,
			1'b1, 1'b0, 4'd8, 8'h5a, 14'h0000, 1'b0);
		drain_pipeline();
		report_test("rbw", start);
	endtask

	initial begin
		while (cycle < TIMEOUT_CYCLES) begin
			@(posedge clk);
		end
		$display("timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		rst_n          = 1'b0;
		op_valid       = 1'b0;
		op_lane        = '0;
		alu_opcode     = '0;
		s_data         = '0;
		t_data         = '0;
		imm            = '0;
		use_imm        = 1'b0;
		upd_ov         = 1'b0;
		upd_neg        = 1'b0;
		upd_zero       = 1'b0;
		sprite_re      = 1'b0;
		sprite_we      = 1'b0;
		sprite_action  = '0;
		sprite_addr    = '0;
		sprite_imm     = '0;
		sprite_use_imm = 1'b0;
		model_ov       = '0;
		model_neg      = '0;
		model_zero     = '0;
		for (int i = 0; i < 2048; i++) begin
			mem_known[i] = 1'b0;
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_reset_state();
		alu_random_ops();
		flag_directed_ops();
		sprite_address_sweep();
		read_before_write();
		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_dispatch.sv
rtl/ex_lane.sv
rtl/sprite_writeback.sv
rtl/ex_cluster_top.sv
verification/tb_ex_cluster.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_ex_cluster

verilator --binary --timing -f filelist.f --top-module tb_ex_cluster \
	-Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

if ! grep -q "STATUS: PASS" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0
